// File: list.f
sched_pkg.sv
class_queue_if.sv
strict_arb.sv
ingress_classifier.sv
class_fifo_bank.sv
strict_egress.sv
strict_sched_top.sv
strict_sched_assert.sv
strict_sched_checker.sv
strict_sched_tb.sv

// File: Makefile
# Verilator build, run and lint for the strict-priority scheduler

VERILATOR   ?= verilator
TOP         ?= strict_sched_tb
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
TIMESCALE   ?= 1ns/1ps
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: strict_sched_tb.sv
// Strict-priority scheduler testbench
// Runs a table of traffic phases through the DUT and checks drop and output counts
`default_nettype none

module strict_sched_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import sched_pkg::*;

  // One traffic phase with the drops it must produce
  typedef struct packed {
    logic [7:0] packets;
    logic       drain;
    logic       random_class;
    class_t     fixed_class;
    logic       reset_after;
    logic [3:0] exp_drops;
  } phase_t;

  localparam int num_phases = 10;

  // Fill every class past depth, drain, preempt a class 3 drain, random load, reset
  phase_t phases [num_phases] = '{
    '{8'd5,  1'b0, 1'b0, 2'd0, 1'b0, 4'd1},
    '{8'd5,  1'b0, 1'b0, 2'd1, 1'b0, 4'd1},
    '{8'd5,  1'b0, 1'b0, 2'd2, 1'b0, 4'd1},
    '{8'd5,  1'b0, 1'b0, 2'd3, 1'b0, 4'd1},
    '{8'd0,  1'b1, 1'b0, 2'd0, 1'b0, 4'd0},
    '{8'd4,  1'b0, 1'b0, 2'd3, 1'b0, 4'd0},
    '{8'd1,  1'b1, 1'b0, 2'd0, 1'b0, 4'd0},
    '{8'd40, 1'b1, 1'b1, 2'd0, 1'b0, 4'd0},
    '{8'd3,  1'b0, 1'b1, 2'd0, 1'b1, 4'd0},
    '{8'd10, 1'b1, 1'b1, 2'd0, 1'b0, 4'd0}
  };

  logic clk, reset, in_valid, drain_en;
  class_t in_class;
  data_t in_data;
  logic out_valid, drop;
  class_t out_class, drop_class;
  data_t out_data;
  int pending, drop_seen, out_seen, errors, tb_errors;
  logic [31:0] lfsr_state;

  strict_sched_top i_dut (.*);

  strict_sched_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci step over taps 32, 22, 2 and 1 with the new bit entering at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[6:0], lfsr_state[0]};
    end
  endtask

  function automatic int timeout_cycles();
    int total;
    total = 0;
    for (int p = 0; p < num_phases; p++) total += int'(phases[p].packets);
    return total * 4 + 100;
  endfunction

  // Cycle limit that ends a run whose drain never completes
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles()) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycles);
    $display("errors: checker %0d, testbench %0d", errors, tb_errors);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    phase_t     ph;
    logic [7:0] bits;
    class_t     cls;
    int         drops_before, outs_before;
    reset = 1'b1;
    in_valid = 1'b0;
    in_class = '0;
    in_data = '0;
    drain_en = 1'b0;
    tb_errors = 0;
    lfsr_state = 32'h1f72_2a3a;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int p = 0; p < num_phases; p++) begin
      ph = phases[p];
      drops_before = drop_seen;
      outs_before = out_seen;
      drain_en = ph.drain;
      for (int n = 0; n < int'(ph.packets); n++) begin
        draw_bits(2, bits);
        cls = ph.random_class ? bits[1:0] : ph.fixed_class;
        draw_bits(8, bits);
        in_valid = 1'b1;
        in_class = cls;
        in_data = bits;
        @(negedge clk);
      end
      in_valid = 1'b0;
      // A drop or the last output lands within three edges of the last event
      while (ph.drain && pending != 0) @(negedge clk);
      repeat (3) @(negedge clk);
      if (drop_seen - drops_before != int'(ph.exp_drops)) begin
        $display("mismatch at %0t: drop count expected %0d got %0d", $time,
                 ph.exp_drops, drop_seen - drops_before);
        tb_errors++;
      end
      if (!ph.drain && out_seen != outs_before) begin
        $display("mismatch at %0t: out_valid count expected %0d got %0d", $time,
                 0, out_seen - outs_before);
        tb_errors++;
      end
      if (ph.reset_after) begin
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
      end
    end
    $display("errors: checker %0d, testbench %0d", errors, tb_errors);
    if (errors + tb_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: strict_sched_checker.sv
// Scheduler checker
// Cycle model of the classifier register, the class queues and the strict pick,
// compared against the top-level outputs at every rising edge
`default_nettype none

module strict_sched_checker (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              in_valid,
  input  wire sched_pkg::class_t in_class,
  input  wire sched_pkg::data_t  in_data,
  input  wire logic              drain_en,
  input  wire logic              out_valid,
  input  wire sched_pkg::class_t out_class,
  input  wire sched_pkg::data_t  out_data,
  input  wire logic              drop,
  input  wire sched_pkg::class_t drop_class,
  output int                     pending,
  output int                     drop_seen,
  output int                     out_seen,
  output int                     errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import sched_pkg::*;

  // Packet held by the classifier register, then one queue per class
  logic   m_valid = 1'b0;
  class_t m_class;
  data_t  m_data;
  data_t  model_q [num_classes][$];

  // Outputs expected after the current edge
  logic   exp_out_valid = 1'b0;
  class_t exp_out_class;
  data_t  exp_out_data;
  logic   exp_drop = 1'b0;
  class_t exp_drop_class;
  bit     armed = 1'b0;

  initial begin
    pending   = 0;
    drop_seen = 0;
    out_seen  = 0;
    errors    = 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  always @(posedge clk) begin
    int   pick;
    logic was_full;
    // Outputs before the edge reflect what the model predicted one edge ago
    if (armed) begin
      if (out_valid === 1'b1) out_seen++;
      if (drop === 1'b1) drop_seen++;
      if (out_valid !== exp_out_valid) begin
        report_mismatch("out_valid", 32'(exp_out_valid), 32'(out_valid));
      end else if (exp_out_valid) begin
        if (out_class !== exp_out_class) begin
          report_mismatch("out_class", 32'(exp_out_class), 32'(out_class));
        end
        if (out_data !== exp_out_data) begin
          report_mismatch("out_data", 32'(exp_out_data), 32'(out_data));
        end
      end
      if (drop !== exp_drop) begin
        report_mismatch("drop", 32'(exp_drop), 32'(drop));
      end else if (exp_drop && drop_class !== exp_drop_class) begin
        report_mismatch("drop_class", 32'(exp_drop_class), 32'(drop_class));
      end
    end
    if (reset) begin
      armed         = 1'b1;
      m_valid       = 1'b0;
      exp_out_valid = 1'b0;
      exp_drop      = 1'b0;
      for (int c = 0; c < num_classes; c++) model_q[c].delete();
    end else begin
      // Full is judged on the occupancy before this edge, before any pop
      was_full = m_valid && (model_q[m_class].size() == queue_depth);
      // Class 0 has the highest priority, so the first non-empty class wins
      pick = -1;
      for (int c = 0; c < num_classes && pick < 0; c++) begin
        if (model_q[c].size() != 0) pick = c;
      end
      exp_out_valid = drain_en && (pick >= 0);
      if (exp_out_valid) begin
        exp_out_class = class_t'(pick);
        exp_out_data  = model_q[pick].pop_front();
      end
      exp_drop       = was_full;
      exp_drop_class = m_class;
      if (m_valid && !was_full) model_q[m_class].push_back(m_data);
      m_valid = in_valid;
      m_class = in_class;
      m_data  = in_data;
    end
    // Packets still inside the scheduler, used by the testbench to wait for a drain
    pending = int'(m_valid);
    for (int c = 0; c < num_classes; c++) pending += model_q[c].size();
  end

endmodule

`default_nettype wire

// File: strict_sched_assert.sv
// Scheduler port assertions
// Reset behaviour, drain gating of the output and the origin of drop pulses
`default_nettype none

module strict_sched_assert (
  input wire logic clk,
  input wire logic reset,
  input wire logic in_valid,
  input wire logic drain_en,
  input wire logic out_valid,
  input wire logic drop
);
  timeunit 1ns;
  timeprecision 100ps;

  // Both pulses are cleared by every reset edge
  reset_quiets_pulses: assert property (@(posedge clk) reset |=> !out_valid && !drop)
    else $error("out_valid or drop high during or right after reset");

  // No pop can happen while draining is off
  drain_gates_output: assert property (@(posedge clk) disable iff (reset)
    !drain_en |=> !out_valid)
    else $error("out_valid high in the cycle after drain_en was low");

  // A drop is the registered packet found full, two edges after its strobe
  drop_needs_packet: assert property (@(posedge clk) disable iff (reset)
    drop |-> $past(in_valid, 2))
    else $error("drop high without in_valid two edges earlier");

endmodule

bind strict_sched_top strict_sched_assert i_assert (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .drain_en  (drain_en),
  .out_valid (out_valid),
  .drop      (drop)
);

`default_nettype wire

// File: strict_sched_top.sv
// Strict-priority packet scheduler top level
// Classifier feeds the per-class FIFO bank, which the egress stage drains in
// strict class order
`default_nettype none

module strict_sched_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              in_valid,
  input  wire sched_pkg::class_t in_class,
  input  wire sched_pkg::data_t  in_data,
  input  wire logic              drain_en,
  output logic                   out_valid,
  output sched_pkg::class_t      out_class,
  output sched_pkg::data_t       out_data,
  output logic                   drop,
  output sched_pkg::class_t      drop_class
);

  // Push and pop sides of the FIFO bank
  class_queue_if q_if ();

  // Producer, registers packets and drops on full
  ingress_classifier i_ingress (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_class   (in_class),
    .in_data    (in_data),
    .q          (q_if.writer),
    .drop       (drop),
    .drop_class (drop_class)
  );

  // Buffer, one FIFO per class
  class_fifo_bank i_bank (
    .clk   (clk),
    .reset (reset),
    .q     (q_if.bank)
  );

  // Consumer, strict drain with class 0 first
  strict_egress i_egress (
    .clk       (clk),
    .reset     (reset),
    .drain_en  (drain_en),
    .q         (q_if.reader),
    .out_valid (out_valid),
    .out_class (out_class),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// File: strict_egress.sv
// Strict-priority egress stage
// Picks the highest-priority non-empty class, pops its head entry while draining
// is enabled and presents it as a registered one-cycle output pulse
`default_nettype none

module strict_egress (
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         drain_en,
  class_queue_if.reader     q,
  output logic              out_valid,
  output sched_pkg::class_t out_class,
  output sched_pkg::data_t  out_data
);
  import sched_pkg::*;

  // Arbiter result over the non-empty flags
  logic   any_ready;
  class_t pick;

  strict_arb #(
    .NUM_REQS (num_classes)
  ) i_strict_arb (
    .reqs     (q.nonempty),
    .winner_v (any_ready),
    .winner   (pick)
  );

  // The pick always selects the head entry, the pop only happens while draining
  assign q.pop_class = pick;
  assign q.pop       = drain_en && any_ready;

  // Output pulse follows the popping edge
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= q.pop;
    end
    out_class <= pick;
    out_data  <= q.head_data;
  end

endmodule

`default_nettype wire

// File: class_fifo_bank.sv
// Per-class FIFO bank
// Keeps one circular FIFO for every traffic class and reports full and non-empty
// flags together with the head entry of the class being popped
`default_nettype none

module class_fifo_bank (
  input  wire logic  clk,
  input  wire logic  reset,
  class_queue_if.bank q
);
  import sched_pkg::*;

  // Storage for all classes, indexed by class then by slot
  data_t  mem [num_classes][queue_depth];

  // Pointers and occupancy kept per class
  ptr_t   wr_ptr [num_classes];
  ptr_t   rd_ptr [num_classes];
  count_t count  [num_classes];

  // Decoded push and pop strobes, one bit per class
  class_mask_t push_sel;
  class_mask_t pop_sel;

  always_comb begin
    push_sel = '0;
    pop_sel  = '0;
    push_sel[q.push_class] = q.push;
    pop_sel[q.pop_class]   = q.pop;
  end

  // Payload writes need no reset, the pointers decide what is valid
  always_ff @(posedge clk) begin
    if (q.push) begin
      mem[q.push_class][wr_ptr[q.push_class]] <= q.push_data;
    end
  end

  // Pointer and occupancy update, callers guarantee no overflow or underflow
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < num_classes; c++) begin
        wr_ptr[c] <= '0;
        rd_ptr[c] <= '0;
        count[c]  <= '0;
      end
    end else begin
      for (int c = 0; c < num_classes; c++) begin
        if (push_sel[c]) begin
          wr_ptr[c] <= wr_ptr[c] + 1'b1;
        end
        if (pop_sel[c]) begin
          rd_ptr[c] <= rd_ptr[c] + 1'b1;
        end
        // A push and a pop together leave the occupancy unchanged
        case ({push_sel[c], pop_sel[c]})
          2'b10:   count[c] <= count[c] + 1'b1;
          2'b01:   count[c] <= count[c] - 1'b1;
          default: count[c] <= count[c];
        endcase
      end
    end
  end

  // Status flags come straight from the occupancy
  always_comb begin
    for (int c = 0; c < num_classes; c++) begin
      q.full[c]     = (count[c] == count_t'(queue_depth));
      q.nonempty[c] = (count[c] != '0);
    end
  end

  // Head entry of the class that egress is looking at
  assign q.head_data = mem[q.pop_class][rd_ptr[q.pop_class]];

endmodule

`default_nettype wire

// File: ingress_classifier.sv
// Ingress classifier
// Registers each arriving packet, then pushes it into its class FIFO or drops it
// when that FIFO is full
`default_nettype none

module ingress_classifier (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             in_valid,
  input  wire sched_pkg::class_t in_class,
  input  wire sched_pkg::data_t  in_data,
  class_queue_if.writer         q,
  output logic                  drop,
  output sched_pkg::class_t     drop_class
);
  import sched_pkg::*;

  // Packet held for one cycle while its FIFO is checked
  logic   pkt_valid;
  class_t pkt_class;
  data_t  pkt_data;

  // Only the strobe is control state, class and payload follow it
  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_valid <= 1'b0;
    end else begin
      pkt_valid <= in_valid;
    end
    pkt_class <= in_class;
    pkt_data  <= in_data;
  end

  // Full is taken as it stands this cycle, a pop on the same class does not free a slot
  assign q.push       = pkt_valid && !q.full[pkt_class];
  assign q.push_class = pkt_class;
  assign q.push_data  = pkt_data;

  // The drop pulse lands one cycle after the push would have happened
  always_ff @(posedge clk) begin
    if (reset) begin
      drop <= 1'b0;
    end else begin
      drop <= pkt_valid && q.full[pkt_class];
    end
    drop_class <= pkt_class;
  end

endmodule

`default_nettype wire

// File: strict_arb.sv
// Strict-priority arbiter
// Grants the lowest-numbered active request and flags whether any request is set
`default_nettype none

module strict_arb #(
  parameter int NUM_REQS = sched_pkg::num_classes
) (
  input  wire logic [NUM_REQS-1:0]         reqs,
  output logic                             winner_v,
  output logic [$clog2(NUM_REQS)-1:0]      winner
);

  // Any request at all means there is a valid grant
  assign winner_v = |reqs;

  // Scan from the top down so the lowest set index is the last one written
  always_comb begin
    winner = '0;
    for (int i = NUM_REQS - 1; i >= 0; i--) begin
      if (reqs[i]) begin
        winner = i[$clog2(NUM_REQS)-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: class_queue_if.sv
// Per-class queue interface
// Bundles the push side used by the classifier and the pop side used by egress
`default_nettype none

interface class_queue_if;
  import sched_pkg::*;

  // Push side, one packet per pulse into the FIFO selected by push_class
  logic        push;
  class_t      push_class;
  data_t       push_data;
  class_mask_t full;

  // Pop side, head_data is the head entry of pop_class and is read combinationally
  class_mask_t nonempty;
  logic        pop;
  class_t      pop_class;
  data_t       head_data;

  // Producer drives pushes and only needs the full flags
  modport writer (output push, push_class, push_data, input full);

  // The FIFO bank owns the status flags and the head entry
  modport bank (input push, push_class, push_data, pop, pop_class,
                output full, nonempty, head_data);

  // Consumer selects a class and pops it
  modport reader (output pop, pop_class, input nonempty, head_data);

endinterface

`default_nettype wire

// File: sched_pkg.sv
// Strict-priority scheduler package
// Holds the class count, FIFO depth and the vector types shared by every stage
`default_nettype none

package sched_pkg;

  // Number of traffic classes, class 0 has the highest priority
  localparam int num_classes = 4;

  // Entries held by each per-class FIFO
  localparam int queue_depth = 4;

  // Traffic class number carried with each packet
  typedef logic [1:0] class_t;

  // Packet payload byte
  typedef logic [7:0] data_t;

  // FIFO occupancy, which must reach queue_depth itself
  typedef logic [2:0] count_t;

  // FIFO read or write pointer, wraps naturally since the depth is a power of two
  typedef logic [1:0] ptr_t;

  // One bit per class, used for the full and non-empty flags
  typedef logic [num_classes-1:0] class_mask_t;

endpackage

`default_nettype wire
